//--- rtl/coreSettings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width of the integer subset
`define XLEN 32

// station entries waiting for operands
`define RS_DEPTH 4

// reorder buffer entries, a power of two so the tag pointers wrap on their own
`define ROB_DEPTH 8

// must equal log2 of ROB_DEPTH
`define TAG_W 3

`endif

//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    // operations handled by the execute unit, decoded upstream
    typedef enum logic [4:0] {
        opLui,
        opAuipc,
        opJal,
        opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi,
        opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu,
        opXor, opSrl, opSra, opOr, opAnd
    } opCode;

    // outcome of a branch or jump, reported to the commit side
    typedef enum logic {
        noJump   = 1'b0,
        takeJump = 1'b1
    } jumpFlag;

endpackage

`default_nettype wire

//--- rtl/tomasuloPkg.sv
`default_nettype none

`include "coreSettings.svh"

package tomasuloPkg;

    typedef logic [`XLEN-1:0] dataWord;
    typedef logic [`XLEN-1:0] addrWord;
    typedef logic [`XLEN-1:0] immWord;

    // reorder buffer index, also the name of the producing instruction
    typedef logic [`TAG_W-1:0] robTag;

    // shared by the issue and commit four-phase handshakes
    typedef enum logic [1:0] {
        idle,
        acked,
        waitDrop
    } hsState;

endpackage

`default_nettype wire

//--- rtl/cdbIf.sv
`default_nettype none

interface cdbIf
    import isaPkg::*, tomasuloPkg::*;
();
    logic    valid;
    robTag   tag;
    dataWord value;
    jumpFlag jump;
    addrWord target;

    modport producer (output valid, tag, value, jump, target);

    // the station only needs valid, tag and value, the buffer takes everything
    modport consumer (input valid, tag, value, jump, target);

endinterface

`default_nettype wire

//--- rtl/dispatchIf.sv
`default_nettype none

interface dispatchIf
    import isaPkg::*, tomasuloPkg::*;
();
    logic    valid;
    opCode   op;
    addrWord pc;
    immWord  imm;
    robTag   tag;
    dataWord operand1;
    dataWord operand2;

    // both operands are resolved by the time valid is high
    modport source (output valid, op, pc, imm, tag, operand1, operand2);

    modport sink (input valid, op, pc, imm, tag, operand1, operand2);

endinterface

`default_nettype wire

//--- rtl/reservationStation.sv
`default_nettype none

`include "coreSettings.svh"

module reservationStation
    import isaPkg::*, tomasuloPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      insert,
    input  opCode     insOp,
    input  addrWord   insPc,
    input  immWord    insImm,
    input  robTag     insTag,
    input  logic      src1Ready,
    input  logic      src2Ready,
    input  robTag     src1Tag,
    input  robTag     src2Tag,
    input  dataWord   src1Value,
    input  dataWord   src2Value,
    input  logic      lookupDone1,
    input  logic      lookupDone2,
    input  dataWord   lookupValue1,
    input  dataWord   lookupValue2,
    output logic      hasSpace,
    cdbIf.consumer    cdb,
    dispatchIf.source dispatch
);

    localparam int IdxW = $clog2(`RS_DEPTH);

    // slot index, also used as age (number of older live entries)
    typedef logic [IdxW-1:0] rsIndex;

    logic [`RS_DEPTH-1:0] entValid;
    logic [`RS_DEPTH-1:0] entRdy1;
    logic [`RS_DEPTH-1:0] entRdy2;
    opCode   entOp  [`RS_DEPTH];
    addrWord entPc  [`RS_DEPTH];
    immWord  entImm [`RS_DEPTH];
    robTag   entTag [`RS_DEPTH];
    robTag   entQ1  [`RS_DEPTH];
    robTag   entQ2  [`RS_DEPTH];
    dataWord entV1  [`RS_DEPTH];
    dataWord entV2  [`RS_DEPTH];
    rsIndex  entAge [`RS_DEPTH];

    rsIndex  freeIdx;
    rsIndex  selIdx;
    rsIndex  newAge;
    logic    selFound;
    logic    ins1Rdy;
    logic    ins2Rdy;
    dataWord ins1Val;
    dataWord ins2Val;

    assign hasSpace = ~&entValid;

    always_comb begin
        freeIdx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!entValid[i]) begin
                freeIdx = rsIndex'(i);
            end
        end
    end

    // oldest ready entry has the smallest age
    always_comb begin
        selFound = 1'b0;
        selIdx   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (entValid[i] && entRdy1[i] && entRdy2[i] &&
                (!selFound || entAge[i] < entAge[selIdx])) begin
                selFound = 1'b1;
                selIdx   = rsIndex'(i);
            end
        end
    end

    // a new entry is younger than everything still live after this cycle
    assign newAge = rsIndex'($countones(entValid) - int'(selFound));

    assign ins1Rdy = src1Ready || lookupDone1 || (cdb.valid && cdb.tag == src1Tag);
    assign ins2Rdy = src2Ready || lookupDone2 || (cdb.valid && cdb.tag == src2Tag);
    assign ins1Val = src1Ready ? src1Value : (lookupDone1 ? lookupValue1 : cdb.value);
    assign ins2Val = src2Ready ? src2Value : (lookupDone2 ? lookupValue2 : cdb.value);

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (entValid[i] && !entRdy1[i] && cdb.valid && cdb.tag == entQ1[i]) begin
                    entRdy1[i] <= 1'b1;
                    entV1[i]   <= cdb.value;
                end
                if (entValid[i] && !entRdy2[i] && cdb.valid && cdb.tag == entQ2[i]) begin
                    entRdy2[i] <= 1'b1;
                    entV2[i]   <= cdb.value;
                end
                if (selFound && entValid[i] && entAge[i] > entAge[selIdx]) begin
                    entAge[i] <= entAge[i] - 1'b1;
                end
            end
            if (selFound) begin
                entValid[selIdx] <= 1'b0;
            end
            if (insert) begin
                entValid[freeIdx] <= 1'b1;
                entOp[freeIdx]    <= insOp;
                entPc[freeIdx]    <= insPc;
                entImm[freeIdx]   <= insImm;
                entTag[freeIdx]   <= insTag;
                entRdy1[freeIdx]  <= ins1Rdy;
                entRdy2[freeIdx]  <= ins2Rdy;
                entQ1[freeIdx]    <= src1Tag;
                entQ2[freeIdx]    <= src2Tag;
                entV1[freeIdx]    <= ins1Val;
                entV2[freeIdx]    <= ins2Val;
                entAge[freeIdx]   <= newAge;
            end
        end
    end

    assign dispatch.valid    = selFound;
    assign dispatch.op       = entOp[selIdx];
    assign dispatch.pc       = entPc[selIdx];
    assign dispatch.imm      = entImm[selIdx];
    assign dispatch.tag      = entTag[selIdx];
    assign dispatch.operand1 = entV1[selIdx];
    assign dispatch.operand2 = entV2[selIdx];

    // the issue control must never push into a full station
    insertWithSpace: assert property (@(posedge clk) disable iff (rst) insert |-> hasSpace);

endmodule

`default_nettype wire

//--- rtl/executeUnit.sv
`default_nettype none

module executeUnit
    import isaPkg::*, tomasuloPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    dispatchIf.sink dispatch,
    cdbIf.producer cdb
);

    dataWord opA;
    dataWord opB;
    immWord  imm;
    addrWord pc;
    dataWord result;
    jumpFlag jump;
    addrWord target;
    logic    taken;

    assign opA = dispatch.operand1;
    assign opB = dispatch.operand2;
    assign imm = dispatch.imm;
    assign pc  = dispatch.pc;

    always_comb begin
        case (dispatch.op)
            opBeq:   taken = opA == opB;
            opBne:   taken = opA != opB;
            opBlt:   taken = $signed(opA) < $signed(opB);
            opBge:   taken = $signed(opA) >= $signed(opB);
            opBltu:  taken = opA < opB;
            opBgeu:  taken = opA >= opB;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        result = '0;
        jump   = noJump;
        target = '0;
        case (dispatch.op)
            opLui:   result = imm;
            opAuipc: result = pc + imm;
            opJal: begin
                result = pc + addrWord'(4);
                jump   = takeJump;
                target = pc + imm;
            end
            opJalr: begin
                result = pc + addrWord'(4);
                jump   = takeJump;
                target = (opA + imm) & ~addrWord'(1);
            end
            // branches leave a zero result whether taken or not
            opBeq, opBne, opBlt, opBge, opBltu, opBgeu: begin
                if (taken) begin
                    jump   = takeJump;
                    target = pc + imm;
                end
            end
            opAddi:  result = opA + imm;
            opSlti:  result = dataWord'($signed(opA) < $signed(imm));
            opSltiu: result = dataWord'(opA < imm);
            opXori:  result = opA ^ imm;
            opOri:   result = opA | imm;
            opAndi:  result = opA & imm;
            opSlli:  result = opA << imm[4:0];
            opSrli:  result = opA >> imm[4:0];
            opSrai:  result = $signed(opA) >>> imm[4:0];
            opAdd:   result = opA + opB;
            opSub:   result = opA - opB;
            opSll:   result = opA << opB[4:0];
            opSlt:   result = dataWord'($signed(opA) < $signed(opB));
            opSltu:  result = dataWord'(opA < opB);
            opXor:   result = opA ^ opB;
            opSrl:   result = opA >> opB[4:0];
            opSra:   result = $signed(opA) >>> opB[4:0];
            opOr:    result = opA | opB;
            opAnd:   result = opA & opB;
            default: result = '0;
        endcase
    end

    // single producer on the bus, so it is never stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= dispatch.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch.valid) begin
            cdb.tag    <= dispatch.tag;
            cdb.value  <= result;
            cdb.jump   <= jump;
            cdb.target <= target;
        end
    end

    // every broadcast answers exactly one dispatch from the station
    cdbFollowsDispatch: assert property (
        @(posedge clk) disable iff (rst) cdb.valid |-> $past(dispatch.valid)
    );

endmodule

`default_nettype wire

//--- rtl/reorderBuffer.sv
`default_nettype none

`include "coreSettings.svh"

module reorderBuffer
    import isaPkg::*, tomasuloPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    alloc,
    output robTag   allocTag,
    output logic    notFull,
    input  robTag   lookupTag1,
    input  robTag   lookupTag2,
    output logic    lookupDone1,
    output logic    lookupDone2,
    output dataWord lookupValue1,
    output dataWord lookupValue2,
    cdbIf.consumer  cdb,
    output logic    commitReq,
    input  logic    commitAck,
    output robTag   commitTag,
    output dataWord commitValue,
    output jumpFlag commitJump,
    output addrWord commitTarget
);

    localparam int CountW = `TAG_W + 1;

    logic [`ROB_DEPTH-1:0] entValid;
    logic [`ROB_DEPTH-1:0] entDone;
    dataWord entValue  [`ROB_DEPTH];
    jumpFlag entJump   [`ROB_DEPTH];
    addrWord entTarget [`ROB_DEPTH];

    robTag             head;
    robTag             tail;
    logic [CountW-1:0] count;
    hsState            commitState;
    logic              commitFire;

    assign allocTag = tail;
    assign notFull  = count != CountW'(`ROB_DEPTH);

    // a producer that is done but not yet committed forwards its value on insert
    assign lookupDone1  = entValid[lookupTag1] && entDone[lookupTag1];
    assign lookupDone2  = entValid[lookupTag2] && entDone[lookupTag2];
    assign lookupValue1 = entValue[lookupTag1];
    assign lookupValue2 = entValue[lookupTag2];

    assign commitReq    = commitState == idle && entValid[head] && entDone[head];
    assign commitFire   = commitReq && commitAck;
    assign commitTag    = head;
    assign commitValue  = entValue[head];
    assign commitJump   = entJump[head];
    assign commitTarget = entTarget[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            entValid    <= '0;
            entDone     <= '0;
            commitState <= idle;
        end else begin
            if (alloc) begin
                entValid[tail] <= 1'b1;
                entDone[tail]  <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (cdb.valid) begin
                entDone[cdb.tag] <= 1'b1;
            end
            if (commitFire) begin
                entValid[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            count <= count + CountW'(alloc) - CountW'(commitFire);
            case (commitState)
                idle:     if (commitFire) commitState <= waitDrop;
                waitDrop: if (!commitAck) commitState <= idle;
                default:  commitState <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            entValue[cdb.tag]  <= cdb.value;
            entJump[cdb.tag]   <= cdb.jump;
            entTarget[cdb.tag] <= cdb.target;
        end
    end

    allocWhenNotFull: assert property (@(posedge clk) disable iff (rst) alloc |-> notFull);

    // results only land in slots that are reserved and still waiting
    cdbToPendingEntry: assert property (
        @(posedge clk) disable iff (rst)
        cdb.valid |-> entValid[cdb.tag] && !entDone[cdb.tag]
    );

endmodule

`default_nettype wire

//--- rtl/tomasuloCore.sv
`default_nettype none

module tomasuloCore
    import isaPkg::*, tomasuloPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    issueReq,
    input  opCode   issueOp,
    input  addrWord issuePc,
    input  immWord  issueImm,
    input  logic    src1Ready,
    input  robTag   src1Tag,
    input  dataWord src1Value,
    input  logic    src2Ready,
    input  robTag   src2Tag,
    input  dataWord src2Value,
    output logic    issueAck,
    output robTag   issueTag,
    output logic    commitReq,
    output robTag   commitTag,
    output dataWord commitValue,
    output jumpFlag commitJump,
    output addrWord commitTarget,
    input  logic    commitAck
);

    cdbIf      cdbBus ();
    dispatchIf dispatchBus ();

    hsState  issueState;
    logic    insert;
    logic    hasSpace;
    logic    notFull;
    robTag   allocTag;
    logic    lookupDone1;
    logic    lookupDone2;
    dataWord lookupValue1;
    dataWord lookupValue2;

    // the write into station and buffer happens on the edge that raises issueAck
    assign insert   = issueState == idle && issueReq && hasSpace && notFull;
    assign issueAck = issueState == acked;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueState <= idle;
        end else begin
            case (issueState)
                idle:    if (insert) issueState <= acked;
                acked:   if (!issueReq) issueState <= idle;
                default: issueState <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            issueTag <= allocTag;
        end
    end

    reservationStation rs (
        .clk, .rst, .insert,
        .insOp(issueOp), .insPc(issuePc), .insImm(issueImm), .insTag(allocTag),
        .src1Ready, .src2Ready, .src1Tag, .src2Tag, .src1Value, .src2Value,
        .lookupDone1, .lookupDone2, .lookupValue1, .lookupValue2,
        .hasSpace, .cdb(cdbBus.consumer), .dispatch(dispatchBus.source)
    );

    executeUnit exu (
        .clk, .rst, .dispatch(dispatchBus.sink), .cdb(cdbBus.producer)
    );

    reorderBuffer rob (
        .clk, .rst, .alloc(insert), .allocTag, .notFull,
        .lookupTag1(src1Tag), .lookupTag2(src2Tag),
        .lookupDone1, .lookupDone2, .lookupValue1, .lookupValue2,
        .cdb(cdbBus.consumer),
        .commitReq, .commitAck, .commitTag, .commitValue, .commitJump, .commitTarget
    );

endmodule

`default_nettype wire

//--- verif/tomasuloCoreTb.sv
`default_nettype none

`include "coreSettings.svh"

module tomasuloCoreTb
    import isaPkg::*, tomasuloPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 16;
    // every opcode once, the dependent chain, then the back-pressure burst
    localparam int TotalInstr  = 29 + 6 + 12;
    localparam int CycleLimit  = 40 * TotalInstr + ResetCycles;

    logic    clk;
    logic    rst;
    logic    issueReq;
    opCode   issueOp;
    addrWord issuePc;
    immWord  issueImm;
    logic    src1Ready;
    robTag   src1Tag;
    dataWord src1Value;
    logic    src2Ready;
    robTag   src2Tag;
    dataWord src2Value;
    logic    issueAck;
    robTag   issueTag;
    logic    commitReq;
    robTag   commitTag;
    dataWord commitValue;
    jumpFlag commitJump;
    addrWord commitTarget;
    logic    commitAck;

    // model results in issue order
    dataWord expValQ[$];
    jumpFlag expJumpQ[$];
    addrWord expTargetQ[$];

    dataWord expValue;
    jumpFlag expJump;
    addrWord expTarget;
    robTag   expTag;
    robTag   expIssueTag;
    int      issuedCount;
    int      committedCount;
    int      valueErrors;
    int      protocolErrors;
    int      cycleCount;
    logic    started;
    logic    holdCommits;
    logic    lingerReq;
    string   testName;

    tomasuloCore dut (.*);

    always #50 clk = ~clk;

    function automatic void expectedResult(input opCode op, input addrWord pc,
                                           input immWord imm, input dataWord a,
                                           input dataWord b, output dataWord val,
                                           output jumpFlag jmp, output addrWord tgt);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] si;
        logic taken;
        sa = a;
        sb = b;
        si = imm;
        val = '0;
        jmp = noJump;
        tgt = pc + imm;
        taken = 1'b0;
        case (op)
            opLui:   val = imm;
            opAuipc: val = pc + imm;
            opJal: begin
                val = pc + 32'd4;
                jmp = takeJump;
            end
            opJalr: begin
                val = pc + 32'd4;
                jmp = takeJump;
                tgt = a + imm;
                tgt[0] = 1'b0;
            end
            opBeq:   taken = a == b;
            opBne:   taken = a != b;
            opBlt:   taken = sa < sb;
            opBge:   taken = !(sa < sb);
            opBltu:  taken = a < b;
            opBgeu:  taken = !(a < b);
            opAddi:  val = a + imm;
            opSlti:  val = {31'b0, sa < si};
            opSltiu: val = {31'b0, a < imm};
            opXori:  val = a ^ imm;
            opOri:   val = a | imm;
            opAndi:  val = a & imm;
            opSlli:  val = a << imm[4:0];
            opSrli:  val = a >> imm[4:0];
            opSrai:  val = sa >>> imm[4:0];
            opAdd:   val = a + b;
            opSub:   val = a - b;
            opSll:   val = a << b[4:0];
            opSlt:   val = {31'b0, sa < sb};
            opSltu:  val = {31'b0, a < b};
            opXor:   val = a ^ b;
            opSrl:   val = a >> b[4:0];
            opSra:   val = sa >>> b[4:0];
            opOr:    val = a | b;
            opAnd:   val = a & b;
            default: val = '0;
        endcase
        if (taken) jmp = takeJump;
    endfunction

    function automatic void reportMismatch(input string what, input logic [31:0] expected,
                                           input logic [31:0] actual);
        valueErrors++;
        $display("Error %s: %s expected %h, actual %h", testName, what, expected, actual);
    endfunction

    function automatic void protocolFault(input string what);
        protocolErrors++;
        $display("handshake problem in %s at cycle %0d: %s", testName, cycleCount, what);
    endfunction

    // full four-phase issue of one instruction, called just after a clock edge
    task automatic issueOne(input opCode op, input immWord imm,
                            input logic rdy1, input robTag tag1, input dataWord val1,
                            input logic rdy2, input robTag tag2, input dataWord val2,
                            output dataWord res);
        addrWord pc;
        jumpFlag jmp;
        addrWord tgt;
        int      holdCycles;
        pc = $urandom & 32'hffff_fffc;
        expectedResult(op, pc, imm, val1, val2, res, jmp, tgt);
        expValQ.push_back(res);
        expJumpQ.push_back(jmp);
        expTargetQ.push_back(tgt);
        expIssueTag = robTag'(issuedCount);
        issueOp = op;
        issuePc = pc;
        issueImm = imm;
        src1Ready = rdy1;
        src1Tag = tag1;
        // sources still waiting carry junk that the station has to ignore
        src1Value = rdy1 ? val1 : $urandom;
        src2Ready = rdy2;
        src2Tag = tag2;
        src2Value = rdy2 ? val2 : $urandom;
        issueReq = 1'b1;
        started = 1'b1;
        while (!issueAck) begin
            @(posedge clk);
            #1;
        end
        issuedCount++;
        // keep the request up past the ack so issueAck has to wait for the drop
        if (lingerReq) begin
            holdCycles = 1 + $urandom % 2;
            repeat (holdCycles) begin
                @(posedge clk);
                #1;
            end
        end
        issueReq = 1'b0;
        while (issueAck) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitDrain();
        while (committedCount != issuedCount) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runChains();
        int      base;
        immWord  lastImm;
        dataWord x;
        dataWord y;
        dataWord v0;
        dataWord v1;
        dataWord v2;
        dataWord v3;
        dataWord v4;
        dataWord v5;
        jumpFlag jmp;
        addrWord tgt;
        base = issuedCount;
        x = $urandom;
        y = $urandom;
        lastImm = $urandom;
        holdCommits = 1'b1;
        issueOne(opAddi, $urandom, 1'b1, '0, x, 1'b1, '0, '0, v0);
        // next in line picks its source off the CDB in the insert cycle
        issueOne(opAdd, '0, 1'b0, robTag'(base), v0, 1'b1, '0, $urandom, v1);
        issueOne(opSub, '0, 1'b0, robTag'(base), v0, 1'b0, robTag'(base + 1), v1, v2);
        issueOne(opXor, '0, 1'b0, robTag'(base + 1), v1, 1'b0, robTag'(base + 2), v2, v3);
        // this consumer goes in ahead of its producer and waits in the station
        expectedResult(opAddi, '0, lastImm, y, '0, v5, jmp, tgt);
        issueOne(opSltu, '0, 1'b0, robTag'(base + 5), v5, 1'b0, robTag'(base + 3), v3, v4);
        issueOne(opAddi, lastImm, 1'b1, '0, y, 1'b1, '0, '0, v5);
        holdCommits = 1'b0;
    endtask

    task automatic runBackPressure();
        int      base;
        dataWord r;
        base = issuedCount;
        holdCommits = 1'b1;
        fork
            begin
                repeat (12) begin
                    issueOne(opCode'(19 + $urandom % 10), $urandom,
                             1'b1, '0, $urandom, 1'b1, '0, $urandom, r);
                end
            end
            begin
                while (issuedCount < base + `ROB_DEPTH) begin
                    @(posedge clk);
                end
                repeat (30) @(posedge clk);
                #1;
                holdCommits = 1'b0;
            end
        join
    endtask

    // commit receiver with random ack delays
    initial begin
        int ackDelay;
        commitAck = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (commitReq && !holdCommits) begin
                if (expValQ.size() == 0) begin
                    protocolFault("commit request with no instruction outstanding");
                end else begin
                    expValue = expValQ.pop_front();
                    expJump = expJumpQ.pop_front();
                    expTarget = expTargetQ.pop_front();
                end
                expTag = robTag'(committedCount);
                ackDelay = $urandom % 3;
                repeat (ackDelay) begin
                    @(posedge clk);
                    #1;
                end
                commitAck = 1'b1;
                @(posedge clk);
                #1;
                committedCount++;
                commitAck = 1'b0;
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles with %0d of %0d instructions committed",
                 cycleCount, committedCount, issuedCount);
        $display("Test failures found");
        $finish;
    end

    initial begin
        opCode   op;
        dataWord a;
        dataWord r;
        void'($urandom(32'hc67c_b484));
        clk = 1'b0;
        rst = 1'b1;
        issueReq = 1'b0;
        issueOp = opLui;
        issuePc = '0;
        issueImm = '0;
        src1Ready = 1'b0;
        src1Tag = '0;
        src1Value = '0;
        src2Ready = 1'b0;
        src2Tag = '0;
        src2Value = '0;
        expValue = '0;
        expJump = noJump;
        expTarget = '0;
        expTag = '0;
        expIssueTag = '0;
        issuedCount = 0;
        committedCount = 0;
        valueErrors = 0;
        protocolErrors = 0;
        started = 1'b0;
        holdCommits = 1'b0;
        lingerReq = 1'b0;
        testName = "reset";
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        testName = "allOps";
        lingerReq = 1'b1;
        op = op.first();
        repeat (op.num()) begin
            a = $urandom;
            // equal operands half the time so the equality branches get taken too
            issueOne(op, $urandom, 1'b1, '0, a, 1'b1, '0, ($urandom % 2) ? a : $urandom, r);
            op = op.next();
        end
        lingerReq = 1'b0;
        waitDrain();
        testName = "chains";
        runChains();
        waitDrain();
        testName = "backPressure";
        runBackPressure();
        waitDrain();
        $display("%0d value errors, %0d protocol errors, %0d of %0d instructions committed",
                 valueErrors, protocolErrors, committedCount, issuedCount);
        if (valueErrors + protocolErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    quietBeforeIssue: assert property (@(posedge clk) disable iff (rst)
        !started |-> !issueAck && !commitReq)
        else protocolFault("issueAck or commitReq went high before any request");

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(issueAck) |-> $past(issueReq))
        else protocolFault("issueAck rose without issueReq held high");

    ackHeldUntilDrop: assert property (@(posedge clk) disable iff (rst)
        $fell(issueAck) |-> !$past(issueReq))
        else protocolFault("issueAck fell while issueReq was still high");

    issueTagOrder: assert property (@(posedge clk) disable iff (rst)
        $rose(issueAck) |-> issueTag == expIssueTag)
        else reportMismatch("issue tag", 32'(expIssueTag), 32'($sampled(issueTag)));

    // the reorder buffer bounds how many instructions can be in flight
    outstandingLimit: assert property (@(posedge clk) disable iff (rst)
        $rose(issueAck) |-> issuedCount - committedCount <= `ROB_DEPTH)
        else protocolFault("more instructions accepted than the reorder buffer holds");

    commitTagOrder: assert property (@(posedge clk) disable iff (rst)
        commitReq && commitAck |-> commitTag == expTag)
        else reportMismatch("commit tag", 32'(expTag), 32'($sampled(commitTag)));

    commitValueMatch: assert property (@(posedge clk) disable iff (rst)
        commitReq && commitAck |-> commitValue == expValue)
        else reportMismatch("commit value", expValue, $sampled(commitValue));

    commitJumpMatch: assert property (@(posedge clk) disable iff (rst)
        commitReq && commitAck |-> commitJump == expJump)
        else reportMismatch("commit jump", 32'(expJump), 32'($sampled(commitJump)));

    commitTargetMatch: assert property (@(posedge clk) disable iff (rst)
        commitReq && commitAck && expJump == takeJump |-> commitTarget == expTarget)
        else reportMismatch("commit target", expTarget, $sampled(commitTarget));

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/isaPkg.sv
rtl/tomasuloPkg.sv
rtl/cdbIf.sv
rtl/dispatchIf.sv
rtl/reservationStation.sv
rtl/executeUnit.sv
rtl/reorderBuffer.sv
rtl/tomasuloCore.sv
verif/tomasuloCoreTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tomasuloCoreTb -Mdir "$buildDir" -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$buildDir/VtomasuloCoreTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q 'All tests passed!' "$logFile"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
